/* design/axis_spi_bridge.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Mode-0 SPI bridge
// Serializes stream words onto mosi at clk/2 and returns miso words
// Frames are marked with an active-low chip select
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axis_spi_bridge #(
	parameter int DATA_BYTES = spi_pkg::DEFAULT_DATA_BYTES
) (
	input logic clk,
	input logic sresetn,

	// Words to send come in here and received words leave here
	byte_stream_if.sink   in_bus,
	byte_stream_if.source out_bus,

	output logic sck,
	output logic mosi,
	output logic cs_n,
	input  logic miso
);

	localparam int WORD_BITS = DATA_BYTES * 8;
	localparam int CTR_W = $clog2(WORD_BITS);

	// Counter value of the final bit in a word
	localparam logic [CTR_W-1:0] CTR_HIGH = CTR_W'(WORD_BITS - 1);

	spi_pkg::bridge_state_t state;

	// Bit position within the word, advanced on each falling sck
	logic [CTR_W-1:0] bit_ctr;

	// Received bits enter at the bottom and end up MSB first
	logic [WORD_BITS-1:0] rx_shift;

	// Last flag of the word in flight since the tx side pops the word before WAIT
	logic last_q;

	logic last_bit;
	logic sck_rise;
	logic sck_fall;

	assign last_bit = (bit_ctr == CTR_HIGH);

	// With sck low the next clock raises it, and with sck high it drops it
	assign sck_rise = (state == spi_pkg::ST_TRANSFER) && !sck;
	assign sck_fall = (state == spi_pkg::ST_TRANSFER) && sck;

	// Pop the tx word on the falling edge after its final bit
	// The next word then reaches mosi while sck is low
	assign in_bus.ready = sck_fall && last_bit;

	// MSB first straight from the FIFO head, which only changes on a pop
	assign mosi = in_bus.data[CTR_HIGH - bit_ctr];

	// The received word is offered for as long as the FSM sits in WAIT
	assign out_bus.valid = (state == spi_pkg::ST_WAIT);
	assign out_bus.data  = rx_shift;
	assign out_bus.last  = last_q;

	// Control path
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			state   <= spi_pkg::ST_SETUP;
			sck     <= 1'b0;
			bit_ctr <= '0;
			cs_n    <= 1'b1;
		end else begin
			case (state)
				spi_pkg::ST_SETUP: begin
					// Mid-frame cs_n is already low and simply stays there
					if (in_bus.valid) begin
						state <= spi_pkg::ST_TRANSFER;
						cs_n  <= 1'b0;
					end
				end
				spi_pkg::ST_TRANSFER: begin
					// Free-running toggle gives sck at clk/2 starting low
					sck <= !sck;
					if (sck) begin
						if (last_bit) begin
							// This edge brings sck low again, so WAIT starts idle
							bit_ctr <= '0;
							state   <= spi_pkg::ST_WAIT;
						end else begin
							bit_ctr <= bit_ctr + CTR_W'(1);
						end
					end
				end
				spi_pkg::ST_WAIT: begin
					// No sck edges here so a full rx FIFO stalls the bus cleanly
					if (out_bus.ready) begin
						state <= spi_pkg::ST_SETUP;
						// The frame closes together with the handoff of its last word
						if (last_q) begin
							cs_n <= 1'b1;
						end
					end
				end
				default: begin
					state <= spi_pkg::ST_SETUP;
				end
			endcase
		end
	end

	// Data path
	always_ff @(posedge clk) begin
		// Latch the frame marker as the word is taken on
		if ((state == spi_pkg::ST_SETUP) && in_bus.valid) begin
			last_q <= in_bus.last;
		end
		// Sample miso on the clock that raises sck
		if (sck_rise) begin
			rx_shift <= {rx_shift[WORD_BITS-2:0], miso};
		end
	end

endmodule

/* design/byte_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Word FIFO with last flags
// Synchronous first-word-fall-through buffer between two streams
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module byte_fifo #(
	parameter int DATA_BYTES = spi_pkg::DEFAULT_DATA_BYTES,
	parameter int FIFO_DEPTH = spi_pkg::DEFAULT_FIFO_DEPTH
) (
	input logic clk,
	input logic sresetn,

	byte_stream_if.sink   in_bus,
	byte_stream_if.source out_bus
);

	// Index into the storage plus one wrap bit to tell full from empty
	localparam int IDX_W = $clog2(FIFO_DEPTH);
	localparam int PTR_W = IDX_W + 1;

	// Circular storage where each entry holds a word of bytes and its last flag
	spi_pkg::spi_byte_t [DATA_BYTES-1:0] data_mem [FIFO_DEPTH];
	logic last_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	logic full;
	logic empty;
	logic do_write;
	logic do_read;

	assign wr_idx = wr_ptr[IDX_W-1:0];
	assign rd_idx = rd_ptr[IDX_W-1:0];

	// Same index but opposite wrap bits means the writer has lapped the reader
	assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) && (wr_idx == rd_idx);
	assign empty = (wr_ptr == rd_ptr);

	// Input accepts whenever there is room and output offers whenever data sits here
	assign in_bus.ready  = !full;
	assign out_bus.valid = !empty;

	// The head entry falls through to the output without a read cycle
	assign out_bus.data = data_mem[rd_idx];
	assign out_bus.last = last_mem[rd_idx];

	// Only the full condition refuses a write
	// A write into an empty FIFO and a read out of a full one are both ordinary
	assign do_write = in_bus.valid && !full;
	assign do_read  = out_bus.ready && !empty;

	// Storage write port
	always_ff @(posedge clk) begin
		if (do_write) begin
			data_mem[wr_idx] <= in_bus.data;
			last_mem[wr_idx] <= in_bus.last;
		end
	end

	// Pointers move independently so a read and a write can share a cycle
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + PTR_W'(1);
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + PTR_W'(1);
			end
		end
	end

endmodule

/* design/byte_stream_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Byte stream interface
// One valid/ready word stream with a frame-closing last flag
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface byte_stream_if #(
	parameter int DATA_BYTES = spi_pkg::DEFAULT_DATA_BYTES
);

	// A word moves on a rising clk while valid and ready are both high
	logic valid;
	logic ready;

	// Payload and frame marker that the source holds stable until accepted
	logic [DATA_BYTES*8-1:0] data;
	logic last;

	// The producing side of the stream
	modport source (
		output valid,
		output data,
		output last,
		input  ready
	);

	// The consuming side of the stream
	modport sink (
		input  valid,
		input  data,
		input  last,
		output ready
	);

endinterface

/* design/spi_master_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// SPI master top level
// Host streams buffered by FIFOs around the mode-0 SPI bridge
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spi_master_top #(
	parameter int DATA_BYTES = spi_pkg::DEFAULT_DATA_BYTES,
	parameter int FIFO_DEPTH = spi_pkg::DEFAULT_FIFO_DEPTH
) (
	input logic clk,
	input logic sresetn,

	// Host transmit stream
	input  logic                    tx_valid,
	output logic                    tx_ready,
	input  logic [DATA_BYTES*8-1:0] tx_data,
	input  logic                    tx_last,

	// Host receive stream
	output logic                    rx_valid,
	input  logic                    rx_ready,
	output logic [DATA_BYTES*8-1:0] rx_data,
	output logic                    rx_last,

	// SPI bus
	output logic sck,
	output logic mosi,
	output logic cs_n,
	input  logic miso
);

	// Host side into the tx FIFO and tx FIFO into the bridge
	byte_stream_if #(.DATA_BYTES(DATA_BYTES)) tx_in_bus ();
	byte_stream_if #(.DATA_BYTES(DATA_BYTES)) tx_out_bus ();

	// Bridge into the rx FIFO and rx FIFO out to the host
	byte_stream_if #(.DATA_BYTES(DATA_BYTES)) rx_in_bus ();
	byte_stream_if #(.DATA_BYTES(DATA_BYTES)) rx_out_bus ();

	// Host transmit ports feed the tx FIFO input
	assign tx_in_bus.valid = tx_valid;
	assign tx_in_bus.data  = tx_data;
	assign tx_in_bus.last  = tx_last;
	assign tx_ready        = tx_in_bus.ready;

	// The rx FIFO output drives the host receive ports
	assign rx_valid         = rx_out_bus.valid;
	assign rx_data          = rx_out_bus.data;
	assign rx_last          = rx_out_bus.last;
	assign rx_out_bus.ready = rx_ready;

	byte_fifo #(
		.DATA_BYTES(DATA_BYTES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.clk     (clk),
		.sresetn (sresetn),
		.in_bus  (tx_in_bus),
		.out_bus (tx_out_bus)
	);

	axis_spi_bridge #(
		.DATA_BYTES(DATA_BYTES)
	) u_bridge (
		.clk     (clk),
		.sresetn (sresetn),
		.in_bus  (tx_out_bus),
		.out_bus (rx_in_bus),
		.sck     (sck),
		.mosi    (mosi),
		.cs_n    (cs_n),
		.miso    (miso)
	);

	byte_fifo #(
		.DATA_BYTES(DATA_BYTES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.clk     (clk),
		.sresetn (sresetn),
		.in_bus  (rx_in_bus),
		.out_bus (rx_out_bus)
	);

endmodule

/* design/spi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// SPI master shared definitions
// Default sizes, the byte type and the bridge FSM states
// ~~~~~~~~~~~~~~~~~~~~

package spi_pkg;

	// Bytes per SPI word when the top level does not override it
	parameter int DEFAULT_DATA_BYTES = 1;

	// Entries per FIFO as a power of two so the pointers wrap cleanly
	parameter int DEFAULT_FIFO_DEPTH = 4;

	// One byte on the wire and the unit that words are built from
	typedef logic [7:0] spi_byte_t;

	// Bridge FSM
	// SETUP waits for a word, TRANSFER clocks it out and WAIT hands the
	// received word downstream
	typedef enum logic [1:0] {
		ST_SETUP    = 2'b00,
		ST_TRANSFER = 2'b01,
		ST_WAIT     = 2'b10
	} bridge_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	-f spi_master_top.f \
	--top-module tb_spi_master \
	-Mdir obj_dir \
	-o tb_sim

# Keep going after a failing run so the log decides the result
./obj_dir/tb_sim > sim.log 2>&1 || true

cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "Test run failed"
	exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "Test run ended without a result"
	exit 1
fi

exit 0

/* spi_master_top.f */
design/spi_pkg.sv
design/byte_stream_if.sv
design/byte_fifo.sv
design/axis_spi_bridge.sv
design/spi_master_top.sv
tests/spi_slave_model.sv
tests/tb_spi_master.sv

/* tests/spi_slave_model.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Behavioral mode-0 SPI slave
// Records mosi bytes and answers with queued bytes on miso
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spi_slave_model (
	input  logic sck,
	input  logic mosi,
	input  logic cs_n,
	output logic miso
);

	// Bytes seen on mosi, in arrival order
	spi_pkg::spi_byte_t rx_q[$];

	// Bytes to return with the head being the byte currently shifted out
	spi_pkg::spi_byte_t resp_q[$];

	// Level of cs_n when each byte completed
	logic cs_q[$];

	spi_pkg::spi_byte_t shift_in;
	int bit_cnt;

	// Bit of the head response at a position counted from the MSB
	function automatic logic resp_bit(int pos);
		if (resp_q.size() == 0) begin
			return 1'b0;
		end
		return resp_q[0][7 - pos];
	endfunction

	initial begin
		miso = 1'b0;
		shift_in = '0;
		bit_cnt = 0;
	end

	// Mode 0 samples mosi on rising sck
	always @(posedge sck) begin
		shift_in = {shift_in[6:0], mosi};
		if (bit_cnt == 7) begin
			rx_q.push_back(shift_in);
			cs_q.push_back(cs_n);
			// The response for this byte has been fully sent
			if (resp_q.size() > 0) begin
				void'(resp_q.pop_front());
			end
			bit_cnt = 0;
		end else begin
			bit_cnt++;
		end
	end

	// The next bit goes out while sck is low
	// A new frame presents its first bit as soon as the slave is selected
	always @(negedge sck or negedge cs_n) begin
		miso = resp_bit(bit_cnt);
	end

endmodule

/* tests/tb_spi_master.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the SPI master
// Runs reset, single, multi-byte, back-pressure and random traffic
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_spi_master;

	localparam int FIFO_DEPTH = spi_pkg::DEFAULT_FIFO_DEPTH;
	localparam int TIMEOUT = 5000;

	logic clk;
	logic sresetn;
	logic tx_valid;
	logic tx_ready;
	logic [7:0] tx_data;
	logic tx_last;
	logic rx_valid;
	logic rx_ready;
	logic [7:0] rx_data;
	logic rx_last;
	logic sck;
	logic mosi;
	logic cs_n;
	logic miso;

	// Scoreboard of bytes sent, responses expected back and their last flags
	spi_pkg::spi_byte_t sent_q[$];
	spi_pkg::spi_byte_t exp_rx_q[$];
	logic exp_last_q[$];

	string test_name = "init";
	int rx_count = 0;
	int slave_checked = 0;
	int cs_rises = 0;
	int sck_rises = 0;
	bit hold_rx = 1'b0;
	bit rand_stall = 1'b0;
	bit saw_tx_full = 1'b0;

	spi_master_top u_spi_master_top (
		.clk(clk), .sresetn(sresetn),
		.tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last),
		.rx_valid(rx_valid), .rx_ready(rx_ready), .rx_data(rx_data), .rx_last(rx_last),
		.sck(sck), .mosi(mosi), .cs_n(cs_n), .miso(miso)
	);

	spi_slave_model u_slave (.sck(sck), .mosi(mosi), .cs_n(cs_n), .miso(miso));

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic fail_value(string what, int exp, int act);
		$display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
		stop_run();
	endtask

	task automatic fail_text(string msg);
		$display("Error in test %s: %s", test_name, msg);
		stop_run();
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// A deselected slave never sees a clock
	a_sck_idle: assert property (@(posedge clk) disable iff (!sresetn) cs_n |-> !sck)
		else fail_text("sck is high while cs_n is deasserted");

	always @(posedge cs_n) cs_rises++;

	// A new byte may only start when the rx FIFO can take the word held by the bridge
	always @(posedge sck) begin
		if (sck_rises % 8 == 0) begin
			assert (sck_rises / 8 - rx_count <= FIFO_DEPTH)
				else fail_text("sck rose while the rx FIFO was full and stalled");
		end
		sck_rises++;
	end

	always @(negedge clk) begin
		if (hold_rx && !tx_ready) saw_tx_full = 1'b1;
	end

	// Host receive side that checks every word as it is taken
	initial begin
		rx_ready = 1'b0;
		forever begin
			@(negedge clk);
			rx_ready = !hold_rx && !(rand_stall && ($urandom % 4 == 0));
			if (rx_valid && rx_ready) begin
				if (exp_rx_q.size() == 0) begin
					fail_text("rx word arrived with nothing expected");
				end
				assert (rx_data == exp_rx_q[0])
					else fail_value("rx_data", exp_rx_q[0], rx_data);
				assert (rx_last == exp_last_q[0])
					else fail_value("rx_last", exp_last_q[0], rx_last);
				void'(exp_rx_q.pop_front());
				void'(exp_last_q.pop_front());
				rx_count++;
			end
		end
	end

	task automatic preload_response(spi_pkg::spi_byte_t b);
		u_slave.resp_q.push_back(b);
		exp_rx_q.push_back(b);
	endtask

	// Offer one byte on the tx stream and hold it until accepted
	task automatic send_byte(spi_pkg::spi_byte_t b, logic last, int gap);
		int t;
		t = 0;
		repeat (gap) @(negedge clk);
		@(negedge clk);
		tx_valid = 1'b1;
		tx_data = b;
		tx_last = last;
		while (!tx_ready) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT) fail_text("tx_ready never rose");
		end
		sent_q.push_back(b);
		exp_last_q.push_back(last);
		@(negedge clk);
		tx_valid = 1'b0;
	endtask

	task automatic wait_rx(int n);
		int t;
		t = 0;
		while (rx_count < n) begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT) fail_text("rx words did not all arrive");
		end
	endtask

	// Compare the bytes the slave saw with the bytes the host sent
	task automatic check_slave();
		assert (u_slave.rx_q.size() == sent_q.size())
			else fail_value("slave byte count", sent_q.size(), u_slave.rx_q.size());
		while (slave_checked < sent_q.size()) begin
			assert (u_slave.rx_q[slave_checked] == sent_q[slave_checked])
				else fail_value("mosi byte", sent_q[slave_checked], u_slave.rx_q[slave_checked]);
			assert (u_slave.cs_q[slave_checked] == 1'b0)
				else fail_value("cs_n at byte end", 0, u_slave.cs_q[slave_checked]);
			slave_checked++;
		end
	endtask

	initial begin
		int rises0;
		int t;
		spi_pkg::spi_byte_t b;
		logic l;
		void'($urandom(32'h61e6));
		sresetn = 1'b0;
		tx_valid = 1'b0;
		tx_data = '0;
		tx_last = 1'b0;
		repeat (10) @(negedge clk);
		sresetn = 1'b1;
		@(negedge clk);

		test_name = "reset";
		assert (sck == 1'b0) else fail_value("sck", 0, sck);
		assert (cs_n == 1'b1) else fail_value("cs_n", 1, cs_n);
		assert (rx_valid == 1'b0) else fail_value("rx_valid", 0, rx_valid);
		assert (tx_ready == 1'b1) else fail_value("tx_ready", 1, tx_ready);

		test_name = "single";
		preload_response(8'h3c);
		send_byte(8'ha5, 1'b1, 0);
		wait_rx(1);
		check_slave();
		assert (cs_n == 1'b1) else fail_value("cs_n after frame", 1, cs_n);

		test_name = "multi";
		rises0 = cs_rises;
		for (int i = 0; i < 5; i++) preload_response(8'(8'h10 + i * 8'h11));
		for (int i = 0; i < 5; i++) send_byte(8'(8'hc0 + i), i == 4, 0);
		wait_rx(6);
		check_slave();
		assert (cs_rises - rises0 == 1) else fail_value("cs_n rises", 1, cs_rises - rises0);

		test_name = "backpressure";
		hold_rx = 1'b1;
		for (int i = 0; i < 10; i++) preload_response(8'(8'h80 + i));
		fork
			for (int i = 0; i < 10; i++) send_byte(8'(8'h40 + i), i == 9, 0);
			begin
				t = 0;
				while (!saw_tx_full) begin
					@(negedge clk);
					t++;
					if (t > TIMEOUT) fail_text("tx_ready never went low under back-pressure");
				end
				repeat (40) @(negedge clk);
				hold_rx = 1'b0;
			end
		join
		wait_rx(16);
		check_slave();

		test_name = "random";
		rand_stall = 1'b1;
		for (int i = 0; i < 200; i++) begin
			b = 8'($urandom);
			l = ($urandom % 5 == 0) || (i == 199);
			preload_response(8'($urandom));
			send_byte(b, l, $urandom % 3);
		end
		wait_rx(216);
		check_slave();
		// The final byte carries last, so the frame must be closed by now
		assert (cs_n == 1'b1) else fail_value("cs_n after final frame", 1, cs_n);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
